// File: rv_slice.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_pipe_ifs.sv
hw/if_stage.sv
hw/decoder.sv
hw/reg_file.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/rv_slice_top.sv
verif/tb_rv_slice.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= rv_slice.f
TB_TOP    ?= tb_rv_slice
RTL_TOP   ?= rv_slice_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)
	./$(SIM_BIN) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_rv_slice.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module tb_rv_slice;

	localparam int N = 30;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	logic [`RV_XLEN-1:0]    in_pc;
	logic [31:0]            in_instr;
	logic                   in_ready;
	logic                   out_ready;
	logic                   out_valid;
	logic [`RV_RADDR_W-1:0] out_rd;
	logic                   out_we;
	logic [`RV_XLEN-1:0]    out_data;
	logic                   out_redirect;
	logic [`RV_XLEN-1:0]    out_target;
	logic                   out_illegal;

	// stimulus columns, then the expected record of each row
	logic [31:0] tab_pc       [N];
	logic [31:0] tab_instr    [N];
	logic        exp_we       [N];
	logic [4:0]  exp_rd       [N];
	logic [31:0] exp_data     [N];
	logic        exp_redirect [N];
	logic [31:0] exp_target   [N];
	logic        exp_illegal  [N];

	logic [31:0] ref_regs [32];
	int          fill;
	int          rec_count;
	int          errors;
	integer      seed;

	rv_slice_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_pc        (in_pc),
		.in_instr     (in_instr),
		.in_ready     (in_ready),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_rd       (out_rd),
		.out_we       (out_we),
		.out_data     (out_data),
		.out_redirect (out_redirect),
		.out_target   (out_target),
		.out_illegal  (out_illegal)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OPC_LUI};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic add_instr(input logic [31:0] w);
		tab_instr[fill] = w;
		tab_pc[fill] = 32'h100 + 32'(4 * fill);
		fill++;
	endtask

	////////////////////////////////////////////////////////////
	// reference model, one row at a time in program order
	////////////////////////////////////////////////////////////

	task automatic predict(input int k);
		logic [31:0] w;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] res;
		logic        wr;
		w = tab_instr[k];
		pc = tab_pc[k];
		a = ref_regs[w[19:15]];
		b = ref_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		res = '0;
		wr = 1'b0;
		exp_redirect[k] = 1'b0;
		exp_target[k] = '0;
		exp_illegal[k] = 1'b0;
		case (w[6:0])
			OPC_OP: begin
				wr = 1'b1;
				case (w[14:12])
					3'b000: res = w[30] ? a - b : a + b;
					3'b010: res = 32'($signed(a) < $signed(b));
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					3'b111: res = a & b;
					default: exp_illegal[k] = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				wr = 1'b1;
				res = a + imm_i;
				exp_illegal[k] = (w[14:12] != 3'b000);
			end
			OPC_LUI: begin
				wr = 1'b1;
				res = {w[31:12], 12'b0};
			end
			OPC_BRANCH: begin
				exp_target[k] = pc + imm_b;
				case (w[14:12])
					3'b000: exp_redirect[k] = (a == b);
					3'b001: exp_redirect[k] = (a != b);
					default: exp_illegal[k] = 1'b1;
				endcase
			end
			OPC_JAL: begin
				wr = 1'b1;
				res = pc + 32'd4;
				exp_redirect[k] = 1'b1;
				exp_target[k] = pc + imm_j;
			end
			OPC_JALR: begin
				wr = 1'b1;
				res = pc + 32'd4;
				exp_redirect[k] = 1'b1;
				exp_target[k] = (a + imm_i) & ~32'h1;
			end
			default: exp_illegal[k] = 1'b1;
		endcase
		if (exp_illegal[k]) begin
			wr = 1'b0;
		end
		exp_we[k] = wr && w[11:7] != 5'd0;
		exp_rd[k] = w[11:7];
		exp_data[k] = res;
		if (exp_we[k]) begin
			ref_regs[w[11:7]] = res;
		end
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// every record leaving execute is matched against the next row
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (rec_count >= N) begin
				errors++;
				$display("extra record at %0t ns beyond the %0d expected", $time, N);
			end else begin
				compare($sformatf("record %0d out_we", rec_count), 32'(out_we),
					32'(exp_we[rec_count]));
				compare($sformatf("record %0d out_illegal", rec_count), 32'(out_illegal),
					32'(exp_illegal[rec_count]));
				compare($sformatf("record %0d out_redirect", rec_count), 32'(out_redirect),
					32'(exp_redirect[rec_count]));
				if (exp_we[rec_count]) begin
					compare($sformatf("record %0d out_rd", rec_count), 32'(out_rd),
						32'(exp_rd[rec_count]));
					compare($sformatf("record %0d out_data", rec_count), out_data,
						exp_data[rec_count]);
				end
				if (exp_redirect[rec_count]) begin
					compare($sformatf("record %0d out_target", rec_count), out_target,
						exp_target[rec_count]);
				end
			end
			rec_count++;
		end
	end

	// random back-pressure, low about one cycle in four
	initial begin
		seed = 32'h6a6e;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			out_ready <= ($random(seed) & 3) != 0;
		end
	end

	initial begin
		repeat (N * 20) @(posedge clk);
		$display("timeout: %0d of %0d records seen after %0d cycles", rec_count, N, N * 20);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_pc = '0;
		in_instr = '0;
		fill = 0;
		rec_count = 0;
		errors = 0;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end

		add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
		add_instr(i_type(12'hFFD, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
		add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		add_instr(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
		add_instr(r_type(7'h00, 5'd1, 5'd3, 3'b111, 5'd5));
		add_instr(r_type(7'h00, 5'd1, 5'd4, 3'b110, 5'd6));
		add_instr(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd7));
		add_instr(r_type(7'h00, 5'd3, 5'd4, 3'b010, 5'd8));
		add_instr(i_type(12'hFF9, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
		add_instr(r_type(7'h00, 5'd1, 5'd9, 3'b010, 5'd10));
		add_instr(r_type(7'h00, 5'd9, 5'd1, 3'b010, 5'd11));
		add_instr(u_type(20'hABCDE, 5'd12));
		add_instr(i_type(12'h123, 5'd12, 3'b000, 5'd12, OPC_OP_IMM));
		// branches, taken and not taken
		add_instr(b_type(13'd16, 5'd5, 5'd1, 3'b000));
		add_instr(b_type(13'h1FF8, 5'd2, 5'd1, 3'b000));
		add_instr(b_type(13'd32, 5'd2, 5'd1, 3'b001));
		add_instr(b_type(13'd12, 5'd6, 5'd3, 3'b001));
		// jumps, a jalr fed by the instruction just before it
		add_instr(j_type(21'h40, 5'd13));
		add_instr(i_type(12'h031, 5'd1, 3'b000, 5'd14, OPC_JALR));
		add_instr(i_type(12'd0, 5'd13, 3'b000, 5'd15, OPC_OP_IMM));
		add_instr(i_type(12'd5, 5'd15, 3'b000, 5'd19, OPC_JALR));
		add_instr(i_type(12'd3, 5'd13, 3'b000, 5'd0, OPC_JALR));
		add_instr(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd16));
		add_instr(j_type(21'h1FFFE0, 5'd0));
		// unknown opcode and an unsupported op-imm
		add_instr(32'hFFFF_FFFF);
		add_instr(i_type(12'd1, 5'd1, 3'b001, 5'd20, OPC_OP_IMM));
		add_instr(i_type(12'd1, 5'd16, 3'b000, 5'd17, OPC_OP_IMM));
		add_instr(u_type(20'h12345, 5'd0));
		add_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd18));
		add_instr(b_type(13'd4, 5'd0, 5'd18, 3'b000));

		if (fill != N) begin
			errors++;
			$display("stimulus table holds %0d rows instead of %0d", fill, N);
		end
		for (int k = 0; k < N; k++) begin
			predict(k);
		end

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < N; i++) begin
			in_valid <= 1'b1;
			in_pc <= tab_pc[i];
			in_instr <= tab_instr[i];
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
		end
		in_valid <= 1'b0;

		wait (rec_count >= N);
		// a few more cycles to catch a repeated record
		repeat (10) @(posedge clk);

		$display("done: %0d of %0d records, %0d errors", rec_count, N, errors);
		if (errors == 0 && rec_count == N) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/rv_slice_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module rv_slice_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic [`RV_XLEN-1:0]    in_pc,
	input  logic [31:0]            in_instr,
	output logic                   in_ready,
	input  logic                   out_ready,
	output logic                   out_valid,
	output logic [`RV_RADDR_W-1:0] out_rd,
	output logic                   out_we,
	output logic [`RV_XLEN-1:0]    out_data,
	output logic                   out_redirect,
	output logic [`RV_XLEN-1:0]    out_target,
	output logic                   out_illegal
);

	if_id_if if_id ();
	id_ex_if id_ex ();
	wb_if    wb ();

	if_stage u_if_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_pc    (in_pc),
		.in_instr (in_instr),
		.in_ready (in_ready),
		.ifid     (if_id.source)
	);

	id_stage u_id_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.ifid  (if_id.sink),
		.idex  (id_ex.source),
		.wb    (wb.sink)
	);

	ex_stage u_ex_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.idex         (id_ex.sink),
		.wb           (wb.source),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_rd       (out_rd),
		.out_we       (out_we),
		.out_data     (out_data),
		.out_redirect (out_redirect),
		.out_target   (out_target),
		.out_illegal  (out_illegal)
	);

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module ex_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	id_ex_if.sink                  idex,
	wb_if.source                   wb,
	input  logic                   out_ready,
	output logic                   out_valid,
	output logic [`RV_RADDR_W-1:0] out_rd,
	output logic                   out_we,
	output logic [`RV_XLEN-1:0]    out_data,
	output logic                   out_redirect,
	output logic [`RV_XLEN-1:0]    out_target,
	output logic                   out_illegal
);

	logic                fwd_a;
	logic                fwd_b;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_y;
	logic                taken;
	logic [`RV_XLEN-1:0] target;

	// the held record is the direct predecessor of the one in idex
	assign fwd_a = out_valid && out_we && out_rd == idex.rs_a && idex.ctrl.porta_sel;
	assign fwd_b = out_valid && out_we && out_rd == idex.rs_b && idex.ctrl.portb_sel;
	assign op_a = fwd_a ? out_data : idex.port_a;
	assign op_b = fwd_b ? out_data : idex.port_b;

	always_comb begin
		case (idex.ctrl.alu_op)
			rv_pkg::ALU_ADD: alu_y = op_a + op_b;
			rv_pkg::ALU_SUB: alu_y = op_a - op_b;
			rv_pkg::ALU_AND: alu_y = op_a & op_b;
			rv_pkg::ALU_OR:  alu_y = op_a | op_b;
			rv_pkg::ALU_XOR: alu_y = op_a ^ op_b;
			rv_pkg::ALU_SLT: alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default:         alu_y = op_b;
		endcase
	end

	assign taken = idex.ctrl.branch_op && ((op_a == op_b) ^ idex.ctrl.branch_ne);

	// a jalr target built in decode missed a forwarded rs1, so rebuild it from the alu
	always_comb begin
		if (!idex.ctrl.jump_op) begin
			target = idex.branch_target;
		end else if (idex.ctrl.jalr_op && fwd_a) begin
			target = {alu_y[`RV_XLEN-1:1], 1'b0};
		end else begin
			target = idex.jump_target;
		end
	end

	assign idex.ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (idex.ready) begin
			out_valid <= idex.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (idex.valid && idex.ready) begin
			out_rd       <= idex.rd;
			out_we       <= idex.ctrl.reg_write && idex.rd != '0;
			out_data     <= idex.ctrl.jump_op ? idex.pc_add4 : alu_y;
			out_redirect <= idex.ctrl.jump_op || taken;
			out_target   <= target;
			out_illegal  <= idex.ctrl.illegal;
		end
	end

	////////////////////////////////////////////////////////////
	// write-back on the transfer edge
	////////////////////////////////////////////////////////////

	assign wb.we    = out_valid && out_ready && out_we;
	assign wb.waddr = out_rd;
	assign wb.wdata = out_data;

	a_idex_hold: assert property (@(posedge clk) disable iff (!rst_n)
		idex.valid && !idex.ready |=> idex.valid
			&& $stable({idex.ctrl, idex.port_a, idex.port_b, idex.rs_a, idex.rs_b, idex.rd,
				idex.pc_add4, idex.branch_target, idex.jump_target}));

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module id_stage (
	input  logic      clk,
	input  logic      rst_n,
	if_id_if.sink     ifid,
	id_ex_if.source   idex,
	wb_if.sink        wb
);

	rv_pkg::ctrl_t          ctrl;
	logic [`RV_XLEN-1:0]    imm;
	logic [`RV_RADDR_W-1:0] rs1;
	logic [`RV_RADDR_W-1:0] rs2;
	logic [`RV_RADDR_W-1:0] rd;
	logic [`RV_XLEN-1:0]    rdata_a;
	logic [`RV_XLEN-1:0]    rdata_b;
	logic [`RV_XLEN-1:0]    drs1;
	logic [`RV_XLEN-1:0]    drs2;
	logic [`RV_XLEN-1:0]    jump_sum;

	decoder u_decoder (
		.instr (ifid.instr),
		.ctrl  (ctrl),
		.imm   (imm),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd    (rd)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_a (rs1),
		.raddr_b (rs2),
		.waddr   (wb.waddr),
		.wdata   (wb.wdata),
		.we      (wb.we),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	////////////////////////////////////////////////////////////
	// forwarding from the record leaving execute
	////////////////////////////////////////////////////////////

	assign drs1 = (wb.we && rs1 != '0 && wb.waddr == rs1) ? wb.wdata : rdata_a;
	assign drs2 = (wb.we && rs2 != '0 && wb.waddr == rs2) ? wb.wdata : rdata_b;

	// jal is pc relative, jalr is rs1 relative
	assign jump_sum = (ctrl.jalr_op ? drs1 : ifid.pc) + imm;

	assign ifid.ready = !idex.valid || idex.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex.valid <= 1'b0;
		end else if (ifid.ready) begin
			idex.valid <= ifid.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ifid.valid && ifid.ready) begin
			idex.ctrl          <= ctrl;
			idex.port_a        <= ctrl.porta_sel ? drs1 : ifid.pc_add4;
			idex.port_b        <= ctrl.portb_sel ? drs2 : imm;
			idex.rs_a          <= rs1;
			idex.rs_b          <= rs2;
			idex.rd            <= rd;
			idex.pc_add4       <= ifid.pc_add4;
			idex.branch_target <= ifid.pc + imm;
			idex.jump_target   <= {jump_sum[`RV_XLEN-1:1], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`RV_RADDR_W-1:0] raddr_a,
	input  logic [`RV_RADDR_W-1:0] raddr_b,
	input  logic [`RV_RADDR_W-1:0] waddr,
	input  logic [`RV_XLEN-1:0]    wdata,
	input  logic                   we,
	output logic [`RV_XLEN-1:0]    rdata_a,
	output logic [`RV_XLEN-1:0]    rdata_b
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is never written, so it always reads zero
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: hw/decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module decoder (
	input  rv_pkg::instr_u           instr,
	output rv_pkg::ctrl_t            ctrl,
	output logic [`RV_XLEN-1:0]      imm,
	output logic [`RV_RADDR_W-1:0]   rs1,
	output logic [`RV_RADDR_W-1:0]   rs2,
	output logic [`RV_RADDR_W-1:0]   rd
);

	assign rs1 = instr.r.rs1;
	assign rs2 = instr.r.rs2;
	assign rd  = instr.r.rd;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = rv_pkg::ALU_ADD;
		imm = '0;

		case (instr.r.opcode)
			rv_pkg::OPC_OP: begin
				ctrl.reg_write = 1'b1;
				ctrl.porta_sel = 1'b1;
				ctrl.portb_sel = 1'b1;
				case (instr.r.funct3)
					3'b000: ctrl.alu_op = instr.r.funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b010: ctrl.alu_op = rv_pkg::ALU_SLT;
					3'b100: ctrl.alu_op = rv_pkg::ALU_XOR;
					3'b110: ctrl.alu_op = rv_pkg::ALU_OR;
					3'b111: ctrl.alu_op = rv_pkg::ALU_AND;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			rv_pkg::OPC_OP_IMM: begin
				// only addi in this slice
				ctrl.reg_write = 1'b1;
				ctrl.porta_sel = 1'b1;
				ctrl.illegal = (instr.i.funct3 != 3'b000);
				imm = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
			end
			rv_pkg::OPC_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = rv_pkg::ALU_PASS_B;
				imm = {instr.u.imm31_12, 12'b0};
			end
			rv_pkg::OPC_BRANCH: begin
				ctrl.porta_sel = 1'b1;
				ctrl.portb_sel = 1'b1;
				ctrl.illegal = (instr.b.funct3[2:1] != 2'b00);
				ctrl.branch_op = !ctrl.illegal;
				ctrl.branch_ne = instr.b.funct3[0];
				imm = {{(`RV_XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
					instr.b.imm10_5, instr.b.imm4_1, 1'b0};
			end
			rv_pkg::OPC_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump_op = 1'b1;
				imm = {{(`RV_XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
					instr.j.imm11, instr.j.imm10_1, 1'b0};
			end
			rv_pkg::OPC_JALR: begin
				// alu forms rs1 + imm, used in execute when rs1 is forwarded there
				ctrl.reg_write = 1'b1;
				ctrl.jump_op = 1'b1;
				ctrl.jalr_op = 1'b1;
				ctrl.porta_sel = 1'b1;
				imm = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
			end
			default: ctrl.illegal = 1'b1;
		endcase

		if (ctrl.illegal) begin
			ctrl.reg_write = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/if_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

module if_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic [`RV_XLEN-1:0] in_pc,
	input  logic [31:0]         in_instr,
	output logic                in_ready,
	if_id_if.source             ifid
);

	// take a new pair when empty or when the held one leaves
	assign in_ready = !ifid.valid || ifid.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid.valid <= 1'b0;
		end else if (in_ready) begin
			ifid.valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			ifid.pc      <= in_pc;
			ifid.pc_add4 <= in_pc + `RV_XLEN'(4);
			ifid.instr   <= in_instr;
		end
	end

	a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable({in_pc, in_instr}));

endmodule

`default_nettype wire

// File: hw/rv_pipe_ifs.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_params.svh"

// fetch side to decode
interface if_id_if;
	logic                valid;
	logic                ready;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] pc_add4;
	logic [31:0]         instr;

	modport source (output valid, pc, pc_add4, instr, input ready);
	modport sink (input valid, pc, pc_add4, instr, output ready);
endinterface

// decode to execute
interface id_ex_if;
	logic                  valid;
	logic                  ready;
	rv_pkg::ctrl_t         ctrl;
	logic [`RV_XLEN-1:0]   port_a;
	logic [`RV_XLEN-1:0]   port_b;
	logic [`RV_RADDR_W-1:0] rs_a;
	logic [`RV_RADDR_W-1:0] rs_b;
	logic [`RV_RADDR_W-1:0] rd;
	logic [`RV_XLEN-1:0]   pc_add4;
	logic [`RV_XLEN-1:0]   branch_target;
	logic [`RV_XLEN-1:0]   jump_target;

	modport source (output valid, ctrl, port_a, port_b, rs_a, rs_b, rd, pc_add4,
		branch_target, jump_target, input ready);
	modport sink (input valid, ctrl, port_a, port_b, rs_a, rs_b, rd, pc_add4,
		branch_target, jump_target, output ready);
endinterface

// write-back, also the decode forwarding source
interface wb_if;
	logic                   we;
	logic [`RV_RADDR_W-1:0] waddr;
	logic [`RV_XLEN-1:0]    wdata;

	modport source (output we, waddr, wdata);
	modport sink (input we, waddr, wdata);
endinterface

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// instruction formats, msb first
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic    reg_write;
		logic    porta_sel;	// 1 selects rs1, 0 selects pc_add4
		logic    portb_sel;	// 1 selects rs2, 0 selects the immediate
		logic    branch_op;
		logic    branch_ne;
		logic    jump_op;
		logic    jalr_op;
		logic    illegal;
	} ctrl_t;

endpackage

`default_nettype wire

// File: hw/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and pc width
`define RV_XLEN 32

// integer register file
`define RV_NREGS 32
`define RV_RADDR_W 5

`endif
